//--- design/div_array.sv
// --------------------------------------------------------------------------
// Multi-lane divider top: dispatcher, a bank of lanes and the collector
// --------------------------------------------------------------------------

`default_nettype none
`timescale 1ns/10ps

`include "div_macros.svh"

module div_array (
  input  wire logic               clk,
  input  wire logic               reset,
  input  wire logic               req_valid,
  output logic                    req_ready,
  input  wire div_pkg::div_req_t  req,
  output logic                    resp_valid,
  input  wire logic               resp_ready,
  output div_pkg::div_resp_t      resp
);

  import div_pkg::*;

  // dispatcher to lanes
  logic [`DIV_LANES-1:0] lane_req_valid;
  logic [`DIV_LANES-1:0] lane_req_ready;
  div_req_t              lane_req;

  // lanes to collector
  logic [`DIV_LANES-1:0] lane_resp_valid;
  logic [`DIV_LANES-1:0] lane_resp_ready;
  div_resp_t             lane_resp [`DIV_LANES];

  div_dispatch u_dispatch (
    .clk            (clk),
    .reset          (reset),
    .req_valid      (req_valid),
    .req_ready      (req_ready),
    .req            (req),
    .lane_req_valid (lane_req_valid),
    .lane_req_ready (lane_req_ready),
    .lane_req       (lane_req)
  );

  // all lanes share the request payload bus
  for (genvar i = 0; i < `DIV_LANES; i++) begin : g_lane
    div_lane u_lane (
      .clk        (clk),
      .reset      (reset),
      .req_valid  (lane_req_valid[i]),
      .req_ready  (lane_req_ready[i]),
      .req        (lane_req),
      .resp_valid (lane_resp_valid[i]),
      .resp_ready (lane_resp_ready[i]),
      .resp       (lane_resp[i])
    );
  end

  div_collect u_collect (
    .clk             (clk),
    .reset           (reset),
    .lane_resp_valid (lane_resp_valid),
    .lane_resp       (lane_resp),
    .lane_resp_ready (lane_resp_ready),
    .resp_valid      (resp_valid),
    .resp_ready      (resp_ready),
    .resp            (resp)
  );

endmodule

`default_nettype wire

//--- design/div_collect.sv
// --------------------------------------------------------------------------
// Response collector that drains lane results in issue order onto one port
// --------------------------------------------------------------------------

`default_nettype none
`timescale 1ns/10ps

`include "div_macros.svh"

module div_collect (
  input  wire logic                  clk,
  input  wire logic                  reset,
  input  wire logic [`DIV_LANES-1:0] lane_resp_valid,
  input  wire div_pkg::div_resp_t    lane_resp [`DIV_LANES],
  output logic [`DIV_LANES-1:0]      lane_resp_ready,
  output logic                       resp_valid,
  input  wire logic                  resp_ready,
  output div_pkg::div_resp_t         resp
);

  import div_pkg::*;

  // lane whose result goes out next
  // follows the dispatcher in lockstep so order is preserved
  lane_idx_t drain_ptr;
  logic      drain;

  // purely combinational output mux
  assign resp_valid = lane_resp_valid[drain_ptr];
  assign resp       = lane_resp[drain_ptr];

  // only the pointed lane hears the sink's ready
  always_comb begin
    for (int i = 0; i < `DIV_LANES; i++) begin
      lane_resp_ready[i] = resp_ready && (drain_ptr == lane_idx_t'(i));
    end
  end

  assign drain = resp_valid && resp_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      drain_ptr <= '0;
    end else if (drain) begin
      if (drain_ptr == lane_idx_t'(`DIV_LANES - 1)) begin
        drain_ptr <= '0;
      end else begin
        drain_ptr <= drain_ptr + 1'b1;
      end
    end
  end

  // a stalled output keeps its payload until the sink takes it
  a_resp_stable: assert property (
    @(posedge clk) disable iff (reset)
    resp_valid && !resp_ready |=> resp_valid && $stable(resp)
  );

endmodule

`default_nettype wire

//--- design/div_dispatch.sv
// --------------------------------------------------------------------------
// Request dispatcher that issues incoming divisions to the lanes in turn
// --------------------------------------------------------------------------

`default_nettype none
`timescale 1ns/10ps

`include "div_macros.svh"

module div_dispatch (
  input  wire logic                  clk,
  input  wire logic                  reset,
  input  wire logic                  req_valid,
  output logic                       req_ready,
  input  wire div_pkg::div_req_t     req,
  output logic [`DIV_LANES-1:0]      lane_req_valid,
  input  wire logic [`DIV_LANES-1:0] lane_req_ready,
  output div_pkg::div_req_t          lane_req
);

  import div_pkg::*;

  // lane that gets the next request
  lane_idx_t issue_ptr;
  logic      issue;

  // payload fans out to every lane and only the valid is steered
  assign lane_req = req;

  always_comb begin
    for (int i = 0; i < `DIV_LANES; i++) begin
      lane_req_valid[i] = req_valid && (issue_ptr == lane_idx_t'(i));
    end
  end

  // stalls whenever the next lane in order is still busy
  assign req_ready = lane_req_ready[issue_ptr];
  assign issue     = req_valid && req_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      issue_ptr <= '0;
    end else if (issue) begin
      if (issue_ptr == lane_idx_t'(`DIV_LANES - 1)) begin
        issue_ptr <= '0;
      end else begin
        issue_ptr <= issue_ptr + 1'b1;
      end
    end
  end

  // an offered request holds valid and payload until a lane takes it
  a_req_stable: assert property (
    @(posedge clk) disable iff (reset)
    req_valid && !req_ready |=> req_valid && $stable(req)
  );

endmodule

`default_nettype wire

//--- design/div_lane.sv
// --------------------------------------------------------------------------
// Iterative restoring divider lane that retires one quotient bit per cycle
// and fixes up the signs of signed results at the output
// --------------------------------------------------------------------------

`default_nettype none
`timescale 1ns/10ps

`include "div_macros.svh"

module div_lane (
  input  wire logic               clk,
  input  wire logic               reset,
  input  wire logic               req_valid,
  output logic                    req_ready,
  input  wire div_pkg::div_req_t  req,
  output logic                    resp_valid,
  input  wire logic               resp_ready,
  output div_pkg::div_resp_t      resp
);

  localparam int W      = `DIV_WIDTH;
  localparam int STEP_W = $clog2(`DIV_STEPS);

  // counter value on the final iteration
  localparam logic [STEP_W-1:0] LAST_STEP = STEP_W'(`DIV_STEPS - 1);

  localparam logic [1:0] IDLE = 2'd0;
  localparam logic [1:0] CALC = 2'd1;
  localparam logic [1:0] DONE = 2'd2;

  logic [1:0]        state;
  logic [STEP_W-1:0] step;

  // {remainder, quotient} work register with one spare bit on top
  logic [2*W:0]      rq_reg;
  // divisor aligned to the remainder half
  logic [2*W:0]      div_reg;
  logic              quot_neg;
  logic              rem_neg;

  logic              accept;
  logic              drain;
  logic [W-1:0]      a_mag;
  logic [W-1:0]      b_mag;
  logic [2*W:0]      shifted;
  logic [2*W:0]      diff;
  logic [W-1:0]      quot_raw;
  logic [W-1:0]      rem_raw;

  // --------------------------------------------------------------------------
  // control
  // --------------------------------------------------------------------------

  assign req_ready  = (state == IDLE);
  assign resp_valid = (state == DONE);
  assign accept     = req_valid && req_ready;
  assign drain      = resp_valid && resp_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
      step  <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (accept) begin
            state <= CALC;
            step  <= '0;
          end
        end
        CALC: begin
          step <= step + 1'b1;
          // last quotient bit lands on this edge
          if (step == LAST_STEP) begin
            state <= DONE;
          end
        end
        DONE: begin
          // hold the result until the collector takes it
          if (drain) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // --------------------------------------------------------------------------
  // datapath
  // --------------------------------------------------------------------------

  // operand magnitudes are only folded for signed requests
  assign a_mag = (req.signed_op && req.a[W-1]) ? -req.a : req.a;
  assign b_mag = (req.signed_op && req.b[W-1]) ? -req.b : req.b;

  // trial subtraction of the divisor from the shifted partial remainder
  assign shifted = rq_reg << 1;
  assign diff    = shifted - div_reg;

  always_ff @(posedge clk) begin
    if (accept) begin
      rq_reg   <= {{(W+1){1'b0}}, a_mag};
      div_reg  <= {1'b0, b_mag, {W{1'b0}}};
      quot_neg <= req.signed_op && (req.a[W-1] ^ req.b[W-1]);
      // remainder follows the dividend sign
      rem_neg  <= req.signed_op && req.a[W-1];
    end else if (state == CALC) begin
      if (diff[2*W]) begin
        // divisor too big so restore and shift in a zero
        rq_reg <= shifted;
      end else begin
        rq_reg <= {diff[2*W:1], 1'b1};
      end
    end
  end

  assign quot_raw = rq_reg[W-1:0];
  assign rem_raw  = rq_reg[2*W-1:W];

  // sign fix-up on the way out
  assign resp.quot = quot_neg ? -quot_raw : quot_raw;
  assign resp.rem  = rem_neg ? -rem_raw : rem_raw;

  // --------------------------------------------------------------------------
  // checks
  // --------------------------------------------------------------------------

  // the final remainder magnitude is always below a nonzero divisor
  a_rem_bound: assert property (
    @(posedge clk) disable iff (reset)
    resp_valid && (div_reg[2*W-1:W] != '0) |-> rem_raw < div_reg[2*W-1:W]
  );

  // a stalled response keeps its payload until the collector drains it
  a_resp_stable: assert property (
    @(posedge clk) disable iff (reset)
    resp_valid && !resp_ready |=> resp_valid && $stable(resp)
  );

endmodule

`default_nettype wire

//--- design/div_macros.svh
// --------------------------------------------------------------------------
// Divider array sizing macros
// lane count, operand width and iterations per division
// --------------------------------------------------------------------------

`ifndef DIV_MACROS_SVH
`define DIV_MACROS_SVH

// number of divider lanes working in parallel
// the dispatcher and collector pointers wrap at this count
`define DIV_LANES 4

// operand and result width in bits
`define DIV_WIDTH 32

// restoring division retires one quotient bit per cycle
// so a full division takes one step per operand bit
`define DIV_STEPS `DIV_WIDTH

`endif

//--- design/div_pkg.sv
// --------------------------------------------------------------------------
// Divider types shared by the lanes, dispatcher and collector
// --------------------------------------------------------------------------

`default_nettype none

`include "div_macros.svh"

package div_pkg;

  // one division request as it arrives on the input port
  typedef struct packed {
    logic                  signed_op;
    logic [`DIV_WIDTH-1:0] a;
    logic [`DIV_WIDTH-1:0] b;
  } div_req_t;

  // remainder sits in the upper half of the response word
  typedef struct packed {
    logic [`DIV_WIDTH-1:0] rem;
    logic [`DIV_WIDTH-1:0] quot;
  } div_resp_t;

  // pointer into the lane array
  typedef logic [$clog2(`DIV_LANES)-1:0] lane_idx_t;

endpackage

`default_nettype wire

//--- list.f
+incdir+design
design/div_pkg.sv
design/div_lane.sv
design/div_dispatch.sv
design/div_collect.sv
design/div_array.sv
test/div_array_tb.sv

//--- run.sh
#!/bin/sh
# build the divider array testbench with Verilator and run it
# the result is decided by the pass line in the simulation output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Mdir obj_dir --top-module div_array_tb -f list.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vdiv_array_tb)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "STATUS: PASS"; then
  exit 0
fi
echo "pass line not found in simulation output"
exit 1

//--- test/div_array_tb.sv
// --------------------------------------------------------------------------
// Divider array testbench: table of divisions through all lanes, with
// random output back-pressure and an in-order scoreboard
// --------------------------------------------------------------------------

`default_nettype none
`timescale 1ns/10ps

`include "div_macros.svh"

module div_array_tb;

  import div_pkg::*;

  localparam int         NUM_VECS     = 20;
  localparam int         REQ_TIMEOUT  = 400;
  localparam int         RESP_TIMEOUT = 400;
  localparam logic [7:0] LFSR_SEED    = 8'd86;

  // one table row, request fields then the expected result
  typedef struct packed {
    logic                  signed_op;
    logic [`DIV_WIDTH-1:0] a;
    logic [`DIV_WIDTH-1:0] b;
    logic [`DIV_WIDTH-1:0] quot;
    logic [`DIV_WIDTH-1:0] rem;
  } vec_t;

  logic      clk;
  logic      reset;
  logic      req_valid;
  logic      req_ready;
  div_req_t  req;
  logic      resp_valid;
  logic      resp_ready;
  div_resp_t resp;

  vec_t vec_table [NUM_VECS];
  // request transfers so far, read by the response side
  int   issued;
  int   max_in_flight;
  logic saw_stall;

  div_array DUT (
    .clk        (clk),
    .reset      (reset),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .req        (req),
    .resp_valid (resp_valid),
    .resp_ready (resp_ready),
    .resp       (resp)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1);
  endtask

  // 8-bit Fibonacci LFSR, taps 8 6 5 4
  function automatic logic [7:0] lfsr_step(input logic [7:0] s);
    return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
  endfunction

  // --------------------------------------------------------------------------
  // stimulus table: signed_op, a, b, quot, rem
  // --------------------------------------------------------------------------

  task automatic load_vectors();
    // unsigned, incl. small dividend and divisor of one
    vec_table[0]  = '{1'b0, 32'd100,      32'd7,        32'd14,       32'd2};
    vec_table[1]  = '{1'b0, 32'd5,        32'd9,        32'd0,        32'd5};
    vec_table[2]  = '{1'b0, 32'hDEADBEEF, 32'd1,        32'hDEADBEEF, 32'd0};
    vec_table[3]  = '{1'b0, 32'hFFFFFFFF, 32'h10,       32'h0FFFFFFF, 32'hF};
    vec_table[4]  = '{1'b0, 32'h80000000, 32'd3,        32'h2AAAAAAA, 32'd2};
    vec_table[5]  = '{1'b0, 32'd1000000,  32'd1000,     32'd1000,     32'd0};
    vec_table[6]  = '{1'b0, 32'h12345678, 32'h1000,     32'h12345,    32'h678};
    vec_table[7]  = '{1'b0, 32'hFFFFFFFF, 32'hFFFFFFFF, 32'd1,        32'd0};
    // signed, quotient sign from a^b, remainder follows a
    vec_table[8]  = '{1'b1, 32'hFFFFFFF9, 32'd2,        32'hFFFFFFFD, 32'hFFFFFFFF};
    vec_table[9]  = '{1'b1, 32'd7,        32'hFFFFFFFE, 32'hFFFFFFFD, 32'd1};
    vec_table[10] = '{1'b1, 32'hFFFFFFF9, 32'hFFFFFFFE, 32'd3,        32'hFFFFFFFF};
    vec_table[11] = '{1'b1, 32'd7,        32'd2,        32'd3,        32'd1};
    vec_table[12] = '{1'b1, 32'hFFFFFF9C, 32'd7,        32'hFFFFFFF2, 32'hFFFFFFFE};
    vec_table[13] = '{1'b1, 32'd1000,     32'hFFFFFFFD, 32'hFFFFFEB3, 32'd1};
    vec_table[14] = '{1'b1, 32'hFFFFFFFF, 32'h10,       32'd0,        32'hFFFFFFFF};
    vec_table[15] = '{1'b1, 32'h80000000, 32'hFFFFFFFF, 32'h80000000, 32'd0};
    // zero divisor: all-ones quotient magnitude, remainder is the dividend
    vec_table[16] = '{1'b0, 32'h1234,     32'd0,        32'hFFFFFFFF, 32'h1234};
    vec_table[17] = '{1'b0, 32'd0,        32'd0,        32'hFFFFFFFF, 32'd0};
    vec_table[18] = '{1'b1, 32'd7,        32'd0,        32'hFFFFFFFF, 32'd7};
    vec_table[19] = '{1'b1, 32'hFFFFFFF9, 32'd0,        32'd1,        32'hFFFFFFF9};
  endtask

  // --------------------------------------------------------------------------
  // request and response processes
  // --------------------------------------------------------------------------

  // back-to-back issue, holding valid and payload until req_ready
  task automatic drive_requests();
    int i;
    int wait_cycles;
    @(posedge clk);
    for (i = 0; i < NUM_VECS; i++) begin
      req_valid <= 1'b1;
      req       <= '{vec_table[i].signed_op, vec_table[i].a, vec_table[i].b};
      wait_cycles = 0;
      @(negedge clk);
      while (!req_ready) begin
        // next lane in order still busy or undrained
        saw_stall = 1'b1;
        wait_cycles++;
        assert (wait_cycles < REQ_TIMEOUT) else abort_run("timed out waiting for req_ready");
        @(negedge clk);
      end
      // transfer edge
      @(posedge clk);
      issued++;
    end
    req_valid <= 1'b0;
  endtask

  task automatic check_response(input int idx);
    assert (resp.quot === vec_table[idx].quot) else
      abort_run($sformatf("FAILED resp.quot vector %0d: got %h expected %h",
                          idx, resp.quot, vec_table[idx].quot));
    assert (resp.rem === vec_table[idx].rem) else
      abort_run($sformatf("FAILED resp.rem vector %0d: got %h expected %h",
                          idx, resp.rem, vec_table[idx].rem));
  endtask

  // drains in table order, resp_ready from one LFSR bit per cycle
  task automatic collect_responses();
    int         idx;
    int         idle_cycles;
    logic [7:0] lfsr;
    div_resp_t  held;
    logic       held_valid;
    idx         = 0;
    idle_cycles = 0;
    lfsr        = LFSR_SEED;
    held_valid  = 1'b0;
    while (idx < NUM_VECS) begin
      @(posedge clk);
      lfsr = lfsr_step(lfsr);
      resp_ready <= lfsr[0];
      @(negedge clk);
      if (issued - idx > max_in_flight) begin
        max_in_flight = issued - idx;
      end
      // a stalled response must still be there, unchanged
      if (held_valid) begin
        assert (resp_valid) else abort_run("resp_valid dropped while the sink was stalled");
        assert (resp === held) else
          abort_run($sformatf("FAILED resp under back-pressure: got %h expected %h",
                              resp, held));
      end
      held_valid = 1'b0;
      if (resp_valid && resp_ready) begin
        check_response(idx);
        idx++;
        idle_cycles = 0;
      end else begin
        held       = resp;
        held_valid = resp_valid;
        idle_cycles++;
        assert (idle_cycles < RESP_TIMEOUT) else abort_run("timed out waiting for a response");
      end
    end
    @(posedge clk);
    resp_ready <= 1'b1;
  endtask

  // --------------------------------------------------------------------------
  // main sequence
  // --------------------------------------------------------------------------

  initial begin
    reset         <= 1'b1;
    req_valid     <= 1'b0;
    req           <= '0;
    resp_ready    <= 1'b0;
    issued        = 0;
    max_in_flight = 0;
    saw_stall     = 1'b0;
    load_vectors();
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    // idle right out of reset
    assert (req_ready === 1'b1) else
      abort_run($sformatf("FAILED req_ready after reset: got %h expected 1", req_ready));
    assert (resp_valid === 1'b0) else
      abort_run($sformatf("FAILED resp_valid after reset: got %h expected 0", resp_valid));
    fork
      drive_requests();
      collect_responses();
    join
    assert (saw_stall) else abort_run("req_ready never fell while all lanes were busy");
    assert (max_in_flight == `DIV_LANES) else
      abort_run($sformatf("FAILED max_in_flight: got %h expected %h",
                          max_in_flight, `DIV_LANES));
    // every response leaves exactly once
    repeat (2 * `DIV_STEPS) begin
      @(negedge clk);
      assert (!resp_valid) else abort_run("extra response after the last request");
    end
    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire
